// File: design/eth10g_params.svh
//////////////////////////////
// 10G port interface constants
// Widths, queue depths, TUSER field positions and default ports
//////////////////////////////

`ifndef ETH10G_PARAMS_SVH
`define ETH10G_PARAMS_SVH

// Datapath widths
`define ETH10G_DATA_W 64
`define ETH10G_USER_W 128

// Buffer sizes, powers of two
`define ETH10G_RX_DEPTH 64
`define ETH10G_TX_DEPTH 64
`define ETH10G_LEN_FIFO_DEPTH 4

// TUSER metadata fields
`define ETH10G_LEN_LSB 0
`define ETH10G_LEN_W 16
`define ETH10G_SRC_LSB 16
`define ETH10G_DST_LSB 24
`define ETH10G_PORT_W 8

// Port numbers of this board position
`define ETH10G_SRC_PORT 8'h01
`define ETH10G_DST_PORT 8'h00

`endif

// File: design/mac_pkg.sv
//////////////////////////////
// MAC-side types
// Word format of the MAC client interface and the transmit FSM states
//////////////////////////////

`default_nettype none

`include "eth10g_params.svh"

package mac_pkg;

    // One 64-bit client word
    typedef logic [`ETH10G_DATA_W-1:0] mac_data_t;

    // Byte i valid when bit i set, always filled from bit 0 upward
    typedef logic [`ETH10G_DATA_W/8-1:0] mac_bvalid_t;

    // Data word with its byte-valid mask
    typedef struct packed {
        mac_data_t   data;
        mac_bvalid_t bvalid;
    } mac_word_t;

    // Transmit request sequence
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_WAIT_ACK,
        TX_SEND
    } tx_state_t;

endpackage

`default_nettype wire

// File: design/axis_pkg.sv
//////////////////////////////
// AXI stream types
// Beat format and TUSER metadata fields
//////////////////////////////

`default_nettype none

`include "eth10g_params.svh"

package axis_pkg;

    typedef logic [`ETH10G_DATA_W-1:0]   axis_data_t;
    typedef logic [`ETH10G_DATA_W/8-1:0] axis_strb_t;
    typedef logic [`ETH10G_USER_W-1:0]   axis_user_t;

    // Frame byte count carried in TUSER
    typedef logic [`ETH10G_LEN_W-1:0] frame_len_t;

    // One-hot port number
    typedef logic [`ETH10G_PORT_W-1:0] port_t;

    // One transfer on the stream
    typedef struct packed {
        axis_data_t data;
        axis_strb_t strb;
        axis_user_t user;
        logic       last;
    } axis_beat_t;

endpackage

`default_nettype wire

// File: design/rx_queue.sv
//////////////////////////////
// Receive frame queue
// Commits good MAC frames, drops bad or overflowed ones, emits AXI beats
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "eth10g_params.svh"

module rx_queue (
    input  wire                       axi_aclk,
    input  wire                       rst_n,
    input  wire mac_pkg::mac_word_t   rx_word,
    input  wire                       rx_good_frame,
    input  wire                       rx_bad_frame,
    output axis_pkg::axis_beat_t      beat,
    output axis_pkg::frame_len_t      frame_len,
    output logic                      valid,
    input  wire                       ready
);

    localparam int DEPTH     = `ETH10G_RX_DEPTH;
    localparam int ADDR_W    = $clog2(DEPTH);
    localparam int LEN_DEPTH = `ETH10G_LEN_FIFO_DEPTH;
    localparam int LEN_AW    = $clog2(LEN_DEPTH);

    // Frame buffer with a last flag per word
    mac_pkg::mac_word_t   mem [DEPTH];
    logic                 last_mem [DEPTH];
    axis_pkg::frame_len_t len_fifo [LEN_DEPTH];

    logic [ADDR_W:0]   wr_ptr;
    logic [ADDR_W:0]   commit_ptr;
    logic [ADDR_W:0]   rd_ptr;
    logic [ADDR_W:0]   used;
    logic [ADDR_W-1:0] last_idx;
    logic [LEN_AW:0]   len_wr_ptr;
    logic [LEN_AW:0]   len_rd_ptr;
    logic [LEN_AW:0]   len_used;

    logic                 data_word;
    logic                 full;
    logic                 drop;
    logic                 word_wr;
    logic                 commit;
    logic                 pop;
    axis_pkg::frame_len_t byte_cnt;

    // Masks are contiguous, so the byte count is the number of set bits
    function automatic axis_pkg::frame_len_t mask_bytes(input mac_pkg::mac_bvalid_t mask);
        axis_pkg::frame_len_t n;
        n = '0;
        for (int i = 0; i < $bits(mask); i++) begin
            n = n + axis_pkg::frame_len_t'(mask[i]);
        end
        return n;
    endfunction

    //////////////////////////////
    // Write side
    //////////////////////////////

    assign data_word = |rx_word.bvalid;
    assign used      = wr_ptr - rd_ptr;
    assign full      = used[ADDR_W];
    assign word_wr   = data_word && !full && !drop;
    assign len_used  = len_wr_ptr - len_rd_ptr;
    assign last_idx  = wr_ptr[ADDR_W-1:0] - 1'b1;

    // Empty frames and frames with no free length slot are rewound as well
    assign commit = rx_good_frame && !rx_bad_frame && !drop
                    && (wr_ptr != commit_ptr) && !len_used[LEN_AW];

    always_ff @(posedge axi_aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            drop       <= 1'b0;
            byte_cnt   <= '0;
        end else if (rx_good_frame || rx_bad_frame) begin
            if (commit) begin
                commit_ptr <= wr_ptr;
            end else begin
                wr_ptr <= commit_ptr;
            end
            drop     <= 1'b0;
            byte_cnt <= '0;
        end else begin
            if (word_wr) begin
                wr_ptr   <= wr_ptr + 1'b1;
                byte_cnt <= byte_cnt + mask_bytes(rx_word.bvalid);
            end
            // Overflow poisons the rest of the frame
            if (data_word && full) begin
                drop <= 1'b1;
            end
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (word_wr) begin
            mem[wr_ptr[ADDR_W-1:0]]      <= rx_word;
            last_mem[wr_ptr[ADDR_W-1:0]] <= 1'b0;
        end
        if (commit) begin
            last_mem[last_idx]                <= 1'b1;
            len_fifo[len_wr_ptr[LEN_AW-1:0]] <= byte_cnt;
        end
    end

    //////////////////////////////
    // Read side
    //////////////////////////////

    assign valid = (rd_ptr != commit_ptr);
    assign pop   = valid && ready;

    always_comb begin
        beat      = '0;
        beat.data = mem[rd_ptr[ADDR_W-1:0]].data;
        beat.strb = mem[rd_ptr[ADDR_W-1:0]].bvalid;
        beat.last = last_mem[rd_ptr[ADDR_W-1:0]];
    end

    assign frame_len = len_fifo[len_rd_ptr[LEN_AW-1:0]];

    always_ff @(posedge axi_aclk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr     <= '0;
            len_wr_ptr <= '0;
            len_rd_ptr <= '0;
        end else begin
            if (commit) begin
                len_wr_ptr <= len_wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Length entry retires with the frame's last beat
            if (pop && beat.last) begin
                len_rd_ptr <= len_rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/tx_queue.sv
//////////////////////////////
// Transmit frame queue
// Holds AXI frames until complete, then plays them to the MAC
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "eth10g_params.svh"

module tx_queue (
    input  wire                        axi_aclk,
    input  wire                        rst_n,
    input  wire axis_pkg::axis_beat_t  in_beat,
    input  wire                        in_valid,
    output logic                       in_ready,
    output mac_pkg::mac_word_t         tx_word,
    output logic                       tx_start,
    input  wire                        tx_ack
);

    localparam int DEPTH  = `ETH10G_TX_DEPTH;
    localparam int ADDR_W = $clog2(DEPTH);

    mac_pkg::mac_word_t mem [DEPTH];
    logic               last_mem [DEPTH];

    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic [ADDR_W:0] used;
    // Whole frames held in the buffer
    logic [ADDR_W:0] frame_cnt;

    logic push;
    logic push_last;
    logic pop;
    logic pop_last;

    mac_pkg::tx_state_t state;
    mac_pkg::tx_state_t state_next;

    //////////////////////////////
    // AXI side
    //////////////////////////////

    assign used      = wr_ptr - rd_ptr;
    assign in_ready  = !used[ADDR_W];
    assign push      = in_valid && in_ready;
    assign push_last = push && in_beat.last;

    // TUSER is not carried to the MAC
    always_ff @(posedge axi_aclk) begin
        if (push) begin
            mem[wr_ptr[ADDR_W-1:0]]      <= mac_pkg::mac_word_t'{data: in_beat.data,
                                                                bvalid: in_beat.strb};
            last_mem[wr_ptr[ADDR_W-1:0]] <= in_beat.last;
        end
    end

    //////////////////////////////
    // MAC side
    //////////////////////////////

    assign pop      = (state == mac_pkg::TX_SEND);
    assign pop_last = pop && last_mem[rd_ptr[ADDR_W-1:0]];

    always_comb begin
        state_next = state;
        case (state)
            mac_pkg::TX_IDLE: begin
                if (frame_cnt != '0) begin
                    state_next = mac_pkg::TX_WAIT_ACK;
                end
            end
            mac_pkg::TX_WAIT_ACK: begin
                if (tx_ack) begin
                    state_next = mac_pkg::TX_SEND;
                end
            end
            mac_pkg::TX_SEND: begin
                if (pop_last) begin
                    state_next = mac_pkg::TX_IDLE;
                end
            end
            default: state_next = mac_pkg::TX_IDLE;
        endcase
    end

    always_ff @(posedge axi_aclk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= mac_pkg::TX_IDLE;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            frame_cnt <= '0;
        end else begin
            state <= state_next;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_last, pop_last})
                2'b10:   frame_cnt <= frame_cnt + 1'b1;
                2'b01:   frame_cnt <= frame_cnt - 1'b1;
                default: frame_cnt <= frame_cnt;
            endcase
        end
    end

    // Request held as a level until acknowledged
    assign tx_start = (state == mac_pkg::TX_WAIT_ACK);
    assign tx_word  = pop ? mem[rd_ptr[ADDR_W-1:0]] : '0;

endmodule

`default_nettype wire

// File: design/axis_port_tagger.sv
//////////////////////////////
// Port tagger
// Register stage that fills TUSER with length and port numbers
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "eth10g_params.svh"

module axis_port_tagger #(
    parameter axis_pkg::port_t SRC_PORT = `ETH10G_SRC_PORT,
    parameter axis_pkg::port_t DST_PORT = `ETH10G_DST_PORT
) (
    input  wire                        axi_aclk,
    input  wire                        rst_n,
    input  wire axis_pkg::axis_beat_t  in_beat,
    input  wire axis_pkg::frame_len_t  frame_len,
    input  wire                        in_valid,
    output logic                       in_ready,
    output axis_pkg::axis_beat_t       out_beat,
    output logic                       out_valid,
    input  wire                        out_ready
);

    axis_pkg::axis_user_t tagged_user;

    // Metadata for every beat of the frame
    always_comb begin
        tagged_user = '0;
        tagged_user[`ETH10G_LEN_LSB +: `ETH10G_LEN_W] = frame_len;
        tagged_user[`ETH10G_SRC_LSB +: `ETH10G_PORT_W] = SRC_PORT;
        tagged_user[`ETH10G_DST_LSB +: `ETH10G_PORT_W] = DST_PORT;
    end

    // Stage is free when empty or being drained
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge axi_aclk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (in_valid && in_ready) begin
            out_beat.data <= in_beat.data;
            out_beat.strb <= in_beat.strb;
            out_beat.user <= tagged_user;
            out_beat.last <= in_beat.last;
        end
    end

endmodule

`default_nettype wire

// File: design/eth10g_interface.sv
//////////////////////////////
// 10G port interface top
// Receive queue and tagger toward AXI, transmit queue toward the MAC
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "eth10g_params.svh"

module eth10g_interface (
    input  wire                        axi_aclk,
    input  wire                        rst_n,
    // AXI master, received frames
    output axis_pkg::axis_beat_t       m_axis_beat,
    output logic                       m_axis_tvalid,
    input  wire                        m_axis_tready,
    // AXI slave, frames to send
    input  wire axis_pkg::axis_beat_t  s_axis_beat,
    input  wire                        s_axis_tvalid,
    output logic                       s_axis_tready,
    // MAC client side
    input  wire mac_pkg::mac_word_t    rx_word,
    input  wire                        rx_good_frame,
    input  wire                        rx_bad_frame,
    output mac_pkg::mac_word_t         tx_word,
    output logic                       tx_start,
    input  wire                        tx_ack
);

    // Queue to tagger
    axis_pkg::axis_beat_t rx_beat;
    axis_pkg::frame_len_t rx_frame_len;
    logic                 rx_valid;
    logic                 rx_ready;

    rx_queue i_rx_queue (
        .axi_aclk      (axi_aclk),
        .rst_n         (rst_n),
        .rx_word       (rx_word),
        .rx_good_frame (rx_good_frame),
        .rx_bad_frame  (rx_bad_frame),
        .beat          (rx_beat),
        .frame_len     (rx_frame_len),
        .valid         (rx_valid),
        .ready         (rx_ready)
    );

    axis_port_tagger #(
        .SRC_PORT (`ETH10G_SRC_PORT),
        .DST_PORT (`ETH10G_DST_PORT)
    ) i_axis_port_tagger (
        .axi_aclk  (axi_aclk),
        .rst_n     (rst_n),
        .in_beat   (rx_beat),
        .frame_len (rx_frame_len),
        .in_valid  (rx_valid),
        .in_ready  (rx_ready),
        .out_beat  (m_axis_beat),
        .out_valid (m_axis_tvalid),
        .out_ready (m_axis_tready)
    );

    tx_queue i_tx_queue (
        .axi_aclk (axi_aclk),
        .rst_n    (rst_n),
        .in_beat  (s_axis_beat),
        .in_valid (s_axis_tvalid),
        .in_ready (s_axis_tready),
        .tx_word  (tx_word),
        .tx_start (tx_start),
        .tx_ack   (tx_ack)
    );

endmodule

`default_nettype wire

// File: verification/eth10g_interface_properties.sv
//////////////////////////////
// Queue handshake assertions
// Bound to the rx and tx queues
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module eth10g_interface_properties (
    input wire                       axi_aclk,
    input wire                       rst_n,
    input wire axis_pkg::axis_beat_t beat,
    input wire                       valid,
    input wire                       ready,
    input wire                       tx_start,
    input wire                       tx_ack,
    input wire                       sending,
    input wire mac_pkg::mac_word_t   tx_word
);

    int fail_count = 0;

    // Offered beat frozen until taken
    beat_held: assert property (@(posedge axi_aclk) disable iff (!rst_n)
        valid && !ready |=> valid && $stable(beat))
    else begin
        fail_count++;
        $error("beat changed or valid dropped before ready");
    end

    // Request is a level until acknowledged
    start_held: assert property (@(posedge axi_aclk) disable iff (!rst_n)
        tx_start && !tx_ack |=> tx_start)
    else begin
        fail_count++;
        $error("tx_start dropped before tx_ack");
    end

    word_idle: assert property (@(posedge axi_aclk) disable iff (!rst_n)
        !sending |-> tx_word == '0)
    else begin
        fail_count++;
        $error("tx_word nonzero outside TX_SEND");
    end

endmodule

bind rx_queue eth10g_interface_properties i_rx_props (
    .axi_aclk (axi_aclk),
    .rst_n    (rst_n),
    .beat     (beat),
    .valid    (valid),
    .ready    (ready),
    .tx_start (1'b0),
    .tx_ack   (1'b0),
    .sending  (1'b0),
    .tx_word  ('0)
);

bind tx_queue eth10g_interface_properties i_tx_props (
    .axi_aclk (axi_aclk),
    .rst_n    (rst_n),
    .beat     (in_beat),
    .valid    (in_valid),
    .ready    (in_ready),
    .tx_start (tx_start),
    .tx_ack   (tx_ack),
    .sending  (state == mac_pkg::TX_SEND),
    .tx_word  (tx_word)
);

`default_nettype wire

// File: verification/eth10g_interface_tb.sv
//////////////////////////////
// 10G port interface testbench
// Table of rx and tx frames against a MAC model and AXI stream checks
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "eth10g_params.svh"

module eth10g_interface_tb;

    localparam int N_TESTS = 11;

    //////////////////////////////
    // Frame table
    //////////////////////////////

    // Back-pressure column is random m_axis_tready for rx and the ack delay in cycles for tx
    string test_name  [N_TESTS] = '{"rx_min", "rx_partial", "rx_bad", "rx_after_bad",
                                    "rx_overflow", "rx_backpressure", "tx_single",
                                    "tx_fill_a", "tx_fill_b", "tx_fill_c", "rx_max"};
    bit    test_tx    [N_TESTS] = '{0, 0, 0, 0, 0, 0, 1, 1, 1, 1, 0};
    int    test_bytes [N_TESTS] = '{64, 61, 100, 77, 560, 300, 125, 200, 200, 200, 512};
    bit    test_good  [N_TESTS] = '{1, 1, 0, 1, 1, 1, 1, 1, 1, 1, 1};
    int    test_bp    [N_TESTS] = '{0, 0, 0, 0, 0, 1, 3, 120, 5, 5, 1};

    logic                 axi_aclk;
    logic                 rst_n;
    axis_pkg::axis_beat_t m_axis_beat;
    logic                 m_axis_tvalid;
    logic                 m_axis_tready;
    axis_pkg::axis_beat_t s_axis_beat;
    logic                 s_axis_tvalid;
    logic                 s_axis_tready;
    mac_pkg::mac_word_t   rx_word;
    logic                 rx_good_frame;
    logic                 rx_bad_frame;
    mac_pkg::mac_word_t   tx_word;
    logic                 tx_start;
    logic                 tx_ack;

    // Reference model state
    int                   seed = 32'h9206_59ee;
    axis_pkg::axis_beat_t rx_exp_q [$];
    string                rx_name_q [$];
    mac_pkg::mac_word_t   tx_exp_q [$];
    string                tx_name_q [$];
    int                   tx_len_q [$];
    int                   tx_delay_q [$];
    int                   rx_pending = 0;
    int                   tx_pending = 0;
    int                   tx_accepted = 0;
    int                   tx_started = 0;
    bit                   rx_bp_on = 1'b0;
    bit                   tready_low_seen = 1'b0;

    int n_pass = 0;
    int n_fail = 0;
    int n_checks = 0;
    int n_errors = 0;
    int cycles;
    int limit;

    initial begin
        axi_aclk = 1'b0;
        forever #50 axi_aclk = ~axi_aclk;
    end

    eth10g_interface i_dut (
        .axi_aclk      (axi_aclk),
        .rst_n         (rst_n),
        .m_axis_beat   (m_axis_beat),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .s_axis_beat   (s_axis_beat),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .rx_word       (rx_word),
        .rx_good_frame (rx_good_frame),
        .rx_bad_frame  (rx_bad_frame),
        .tx_word       (tx_word),
        .tx_start      (tx_start),
        .tx_ack        (tx_ack)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Lowest n bytes valid
    function automatic logic [7:0] byte_mask(input int n);
        return 8'((1 << n) - 1);
    endfunction

    function automatic logic [63:0] random_word(input logic [7:0] mask);
        logic [63:0] w;
        w = '0;
        for (int b = 0; b < 8; b++) begin
            if (mask[b]) begin
                w[8*b +: 8] = 8'($random(seed));
            end
        end
        return w;
    endfunction

    task automatic check(input string what, input logic [255:0] expected,
                         input logic [255:0] actual, inout int errs);
        n_checks++;
        if (expected !== actual) begin
            $display("MISMATCH %s: expected %0h, actual %0h", what, expected, actual);
            errs++;
            n_errors++;
        end
    endtask

    task automatic report(input string name, input int errs, input string detail);
        if (errs == 0) begin
            n_pass++;
            $display("PASS %s %s", name, detail);
        end else begin
            n_fail++;
            $display("FAIL %s %s", name, detail);
        end
    endtask

    task automatic end_run(input bit timed_out);
        $display("Summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
                 n_pass, n_fail, n_checks, n_errors);
        if (!timed_out && n_fail == 0 && n_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    //////////////////////////////
    // MAC and AXI drivers
    //////////////////////////////

    task automatic send_rx(input int idx, output bit kept);
        int                   nbytes;
        int                   nwords;
        mac_pkg::mac_word_t   w;
        axis_pkg::axis_beat_t b;
        nbytes = test_bytes[idx];
        nwords = (nbytes + 7) / 8;
        // A frame fits the drained buffer when it is no longer than the buffer
        kept = test_good[idx] && (nwords <= `ETH10G_RX_DEPTH);
        if (kept) begin
            rx_name_q.push_back(test_name[idx]);
            rx_pending++;
        end
        for (int i = 0; i < nwords; i++) begin
            w.bvalid = (i == nwords - 1) ? byte_mask(nbytes - 8 * i) : 8'hff;
            w.data   = random_word(w.bvalid);
            if (kept) begin
                b.data = w.data;
                b.strb = w.bvalid;
                b.user = {96'h0, 8'h00, 8'h01, 16'(nbytes)};
                b.last = (i == nwords - 1);
                rx_exp_q.push_back(b);
            end
            @(negedge axi_aclk);
            rx_word = w;
        end
        @(negedge axi_aclk);
        rx_word       = '0;
        rx_good_frame = test_good[idx];
        rx_bad_frame  = !test_good[idx];
        @(negedge axi_aclk);
        rx_good_frame = 1'b0;
        rx_bad_frame  = 1'b0;
    endtask

    task automatic send_tx(input int idx);
        int                   nbytes;
        int                   nwords;
        axis_pkg::axis_beat_t b;
        nbytes = test_bytes[idx];
        nwords = (nbytes + 7) / 8;
        tx_name_q.push_back(test_name[idx]);
        tx_len_q.push_back(nwords);
        tx_delay_q.push_back(test_bp[idx]);
        tx_pending++;
        for (int i = 0; i < nwords; i++) begin
            b.strb = (i == nwords - 1) ? byte_mask(nbytes - 8 * i) : 8'hff;
            b.data = random_word(b.strb);
            // TUSER content must not reach the MAC
            b.user = {$random(seed), $random(seed), $random(seed), $random(seed)};
            b.last = (i == nwords - 1);
            tx_exp_q.push_back(mac_pkg::mac_word_t'{data: b.data, bvalid: b.strb});
            @(negedge axi_aclk);
            s_axis_beat   = b;
            s_axis_tvalid = 1'b1;
            @(posedge axi_aclk);
            while (!s_axis_tready) begin
                tready_low_seen = 1'b1;
                @(posedge axi_aclk);
            end
        end
        @(negedge axi_aclk);
        tx_accepted++;
        s_axis_tvalid = 1'b0;
        s_axis_beat   = '0;
    endtask

    initial begin : tready_driver
        m_axis_tready = 1'b1;
        forever begin
            @(negedge axi_aclk);
            m_axis_tready = rx_bp_on ? 1'($random(seed)) : 1'b1;
        end
    end

    //////////////////////////////
    // Monitors
    //////////////////////////////

    initial begin : rx_monitor
        axis_pkg::axis_beat_t exp;
        int                   errs;
        int                   beats;
        errs  = 0;
        beats = 0;
        forever begin
            @(posedge axi_aclk);
            if (rst_n && m_axis_tvalid && m_axis_tready) begin
                if (rx_exp_q.size() == 0) begin
                    $display("ERROR: beat on m_axis while no rx frame was expected");
                    n_errors++;
                end else begin
                    exp = rx_exp_q.pop_front();
                    check($sformatf("%s beat %0d data", rx_name_q[0], beats),
                          256'(exp.data), 256'(m_axis_beat.data), errs);
                    check($sformatf("%s beat %0d strb", rx_name_q[0], beats),
                          256'(exp.strb), 256'(m_axis_beat.strb), errs);
                    check($sformatf("%s beat %0d user", rx_name_q[0], beats),
                          256'(exp.user), 256'(m_axis_beat.user), errs);
                    check($sformatf("%s beat %0d last", rx_name_q[0], beats),
                          256'(exp.last), 256'(m_axis_beat.last), errs);
                    beats++;
                    if (exp.last) begin
                        report(rx_name_q.pop_front(), errs, $sformatf("(%0d beats)", beats));
                        rx_pending--;
                        errs  = 0;
                        beats = 0;
                    end
                end
            end
        end
    end

    // Answers each request after the frame's ack delay and collects its words
    initial begin : mac_tx_model
        string              name;
        int                 nwords;
        int                 delay;
        int                 errs;
        mac_pkg::mac_word_t exp;
        tx_ack = 1'b0;
        forever begin
            @(posedge axi_aclk);
            if (rst_n && tx_start) begin
                if (tx_name_q.size() == 0) begin
                    $display("ERROR: tx_start raised while no tx frame was offered");
                    n_errors++;
                end else begin
                    errs   = 0;
                    name   = tx_name_q.pop_front();
                    nwords = tx_len_q.pop_front();
                    delay  = tx_delay_q.pop_front();
                    check({name, " start after last beat"}, 256'(1),
                          256'(tx_accepted > tx_started), errs);
                    tx_started++;
                    repeat (delay) @(negedge axi_aclk);
                    @(negedge axi_aclk);
                    tx_ack = 1'b1;
                    @(negedge axi_aclk);
                    tx_ack = 1'b0;
                    // Words must follow on consecutive cycles
                    for (int i = 0; i < nwords; i++) begin
                        @(posedge axi_aclk);
                        exp = tx_exp_q.pop_front();
                        check($sformatf("%s word %0d data", name, i),
                              256'(exp.data), 256'(tx_word.data), errs);
                        check($sformatf("%s word %0d bvalid", name, i),
                              256'(exp.bvalid), 256'(tx_word.bvalid), errs);
                    end
                    tx_pending--;
                    report(name, errs, $sformatf("(%0d words, ack delay %0d)", nwords, delay));
                end
            end
        end
    end

    initial begin : watchdog
        limit = 500;
        for (int i = 0; i < N_TESTS; i++) begin
            limit += 4 * ((test_bytes[i] + 7) / 8);
        end
        cycles = 0;
        while (cycles < limit) begin
            @(posedge axi_aclk);
            cycles++;
        end
        $display("ERROR: run did not finish within %0d cycles", limit);
        end_run(1'b1);
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin : main
        bit kept;
        int errs;
        rst_n         = 1'b0;
        rx_word       = '0;
        rx_good_frame = 1'b0;
        rx_bad_frame  = 1'b0;
        s_axis_beat   = '0;
        s_axis_tvalid = 1'b0;
        repeat (16) @(posedge axi_aclk);
        @(negedge axi_aclk);
        rst_n = 1'b1;

        @(posedge axi_aclk);
        errs = 0;
        check("reset m_axis_tvalid", 256'(0), 256'(m_axis_tvalid), errs);
        check("reset tx_start", 256'(0), 256'(tx_start), errs);
        check("reset tx_word", 256'(0), 256'(tx_word), errs);
        check("reset s_axis_tready", 256'(1), 256'(s_axis_tready), errs);
        report("reset_state", errs, "(outputs idle)");

        for (int i = 0; i < N_TESTS; i++) begin
            if (test_tx[i]) begin
                send_tx(i);
            end else begin
                rx_bp_on = (test_bp[i] != 0);
                send_rx(i, kept);
                if (kept) begin
                    while (rx_pending != 0) begin
                        @(posedge axi_aclk);
                    end
                end else begin
                    errs = 0;
                    repeat (8) begin
                        @(posedge axi_aclk);
                        check({test_name[i], " no m_axis output"}, 256'(0),
                              256'(m_axis_tvalid), errs);
                    end
                    report(test_name[i], errs, "(dropped)");
                end
                rx_bp_on = 1'b0;
            end
        end

        while (rx_pending != 0 || tx_pending != 0) begin
            @(posedge axi_aclk);
        end
        errs = 0;
        check("s_axis_tready low with tx buffer full", 256'(1), 256'(tready_low_seen), errs);
        report("tx_full_stall", errs, "(s_axis_tready fell)");

        n_errors += i_dut.i_rx_queue.i_rx_props.fail_count;
        n_errors += i_dut.i_tx_queue.i_tx_props.fail_count;
        end_run(1'b0);
    end

endmodule

`default_nettype wire

// File: eth10g_interface.f
+incdir+design
design/mac_pkg.sv
design/axis_pkg.sv
design/rx_queue.sv
design/tx_queue.sv
design/axis_port_tagger.sv
design/eth10g_interface.sv
verification/eth10g_interface_properties.sv
verification/eth10g_interface_tb.sv

// File: Makefile
# Verilator flow for the 10G port interface

VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := eth10g_interface_tb
FILELIST  := eth10g_interface.f
OBJ_DIR   := obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# Pass only when the run prints the pass message
sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
